// File: hw/tut_pkg.sv
//==================================================
// Tutankham video package
// Address map, video timing constants and the
// scalar types shared by the video blocks
//==================================================

`default_nettype none

package tut_pkg;

	// Scalar types
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] bus_addr_t;
	typedef logic [14:0] vram_addr_t;
	typedef logic [8:0]  h_cnt_t;
	typedef logic [7:0]  v_cnt_t;
	typedef logic [3:0]  pal_idx_t;
	typedef logic [4:0]  chan_t;

	//==================================================
	// Video timing
	//==================================================

	// System clocks per pixel
	localparam int PIX_DIV = 8;

	// Horizontal line, in pixels
	localparam int H_TOTAL      = 384;
	localparam int H_ACTIVE     = 256;
	localparam int H_SYNC_START = 296;
	localparam int H_SYNC_END   = 328;

	// Vertical frame, in lines
	localparam int V_TOTAL      = 264;
	localparam int V_ACTIVE     = 224;
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_END   = 244;

	// Scroll only applies left of this column
	localparam byte_t SCROLL_LIMIT = 8'd192;

	//==================================================
	// Address map
	//==================================================

	// Video RAM is every address with bit 15 clear
	localparam bus_addr_t PAL_BASE    = 16'h8000;
	localparam int        PAL_ENTRIES = 16;
	localparam bus_addr_t SCROLL_ADDR = 16'h8100;
	localparam bus_addr_t LATCH_BASE  = 16'h8200;

	// Main latch bit positions, one address each
	localparam logic [2:0] LATCH_IRQ_EN = 3'd0;
	localparam logic [2:0] LATCH_FLIP_X = 3'd6;
	localparam logic [2:0] LATCH_FLIP_Y = 3'd7;

	// Open bus value for unmapped reads
	localparam byte_t UNMAPPED_DATA = 8'hFF;

	// AXI response code, the slave never errors
	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: hw/tut_video_timing.sv
//==================================================
// Video timing generator
// Pixel enable, H/V counters, sync, blank and the
// vblank start pulse for the interrupt logic
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tut_video_timing (
	input  wire                clk_49m,
	input  wire                reset,
	output logic               ce_pix_o,
	output logic               hblank_o,
	output logic               vblank_o,
	output logic               hsync_n_o,
	output logic               vsync_n_o,
	output logic               vblank_start_o,
	output tut_pkg::h_cnt_t    h_cnt_o,
	output tut_pkg::v_cnt_t    v_cnt_o
);
	import tut_pkg::*;

	logic [2:0] div_q;
	h_cnt_t     h_q;
	h_cnt_t     h_nxt;
	// Nine bits, the frame is taller than 256 lines
	logic [8:0] v_q;
	logic [8:0] v_nxt;

	// Pixel enable on the last clock of each divider period
	always_ff @(posedge clk_49m) begin
		if (!reset)
			div_q <= '0;
		else
			div_q <= div_q + 3'd1;
	end

	assign ce_pix_o = (div_q == 3'(PIX_DIV - 1));

	// Counter values after the coming pixel tick
	always_comb begin
		h_nxt = h_q + 9'd1;
		v_nxt = v_q;
		if (h_q == h_cnt_t'(H_TOTAL - 1)) begin
			h_nxt = '0;
			if (v_q == 9'(V_TOTAL - 1))
				v_nxt = '0;
			else
				v_nxt = v_q + 9'd1;
		end
	end

	//==================================================
	// Counters and registered compares
	//==================================================

	// Compares use the next values so that flags line up with the counters
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_q       <= '0;
			v_q       <= '0;
			hblank_o  <= 1'b0;
			vblank_o  <= 1'b0;
			hsync_n_o <= 1'b1;
			vsync_n_o <= 1'b1;
		end else if (ce_pix_o) begin
			h_q       <= h_nxt;
			v_q       <= v_nxt;
			hblank_o  <= (h_nxt >= h_cnt_t'(H_ACTIVE));
			vblank_o  <= (v_nxt >= 9'(V_ACTIVE));
			hsync_n_o <= !(h_nxt >= h_cnt_t'(H_SYNC_START) && h_nxt < h_cnt_t'(H_SYNC_END));
			vsync_n_o <= !(v_nxt >= 9'(V_SYNC_START) && v_nxt < 9'(V_SYNC_END));
		end
	end

	// One clock pulse as the first blank line begins
	always_ff @(posedge clk_49m) begin
		if (!reset)
			vblank_start_o <= 1'b0;
		else
			vblank_start_o <= ce_pix_o && (h_nxt == '0) && (v_nxt == 9'(V_ACTIVE));
	end

	assign h_cnt_o = h_q;
	// Lines 256 and up alias onto 0..7, all inside blanking
	assign v_cnt_o = v_q[7:0];

endmodule

`default_nettype wire

// File: hw/tut_bus_slave.sv
//==================================================
// AXI4-Lite bus slave
// Address decode, palette file, scroll register,
// main latch and the vblank interrupt
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tut_bus_slave (
	input  wire                 clk_49m,
	input  wire                 reset,
	// Write address and data
	input  wire                 awvalid_i,
	input  tut_pkg::bus_addr_t  awaddr_i,
	output logic                awready_o,
	input  wire                 wvalid_i,
	input  tut_pkg::byte_t      wdata_i,
	output logic                wready_o,
	// Write response
	output logic                bvalid_o,
	input  wire                 bready_i,
	output logic [1:0]          bresp_o,
	// Read address and data
	input  wire                 arvalid_i,
	input  tut_pkg::bus_addr_t  araddr_i,
	output logic                arready_o,
	output logic                rvalid_o,
	output tut_pkg::byte_t      rdata_o,
	input  wire                 rready_i,
	output logic [1:0]          rresp_o,
	// Video side
	input  wire                 vblank_start_i,
	input  tut_pkg::pal_idx_t   pal_idx_i,
	output tut_pkg::byte_t      pal_byte_o,
	output tut_pkg::byte_t      scroll_o,
	output logic                flip_x_o,
	output logic                flip_y_o,
	output logic                irq_n_o,
	// Video RAM port A
	output logic                vram_we_o,
	output tut_pkg::vram_addr_t vram_addr_o,
	output tut_pkg::byte_t      vram_wdata_o,
	input  tut_pkg::byte_t      vram_rdata_i
);
	import tut_pkg::*;

	byte_t pal_q [PAL_ENTRIES];
	byte_t scroll_q;
	logic  irq_en_q;
	logic  irq_tgl_q;
	logic  wr_rdy_q;
	logic  rd_rdy_q;
	logic  rd_pend_q;
	logic  rd_vram_q;
	byte_t rd_byte_q;
	logic  idle;
	logic  wr_take;
	logic  rd_take;
	logic  wr_fire;
	logic  rd_fire;

	function automatic logic is_pal(input bus_addr_t a);
		return (a >= PAL_BASE) && (a < PAL_BASE + PAL_ENTRIES);
	endfunction

	function automatic logic is_latch(input bus_addr_t a);
		return a[15:3] == LATCH_BASE[15:3];
	endfunction

	//==================================================
	// Handshakes
	//==================================================

	// One transaction at a time, a pending response blocks the next
	assign idle    = !bvalid_o && !rd_pend_q && !rvalid_o && !wr_rdy_q && !rd_rdy_q;
	// Writes win when both channels ask together
	assign wr_take = idle && awvalid_i && wvalid_i;
	assign rd_take = idle && arvalid_i && !wr_take;
	assign wr_fire = wr_rdy_q && awvalid_i && wvalid_i;
	assign rd_fire = rd_rdy_q && arvalid_i;

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			wr_rdy_q  <= 1'b0;
			rd_rdy_q  <= 1'b0;
			bvalid_o  <= 1'b0;
			rd_pend_q <= 1'b0;
			rvalid_o  <= 1'b0;
		end else begin
			wr_rdy_q  <= wr_take;
			rd_rdy_q  <= rd_take;
			rd_pend_q <= rd_fire;
			if (wr_fire)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			// Data lands one clock after the RAM sampled the address
			if (rd_pend_q)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	assign awready_o = wr_rdy_q;
	assign wready_o  = wr_rdy_q;
	assign arready_o = rd_rdy_q;
	assign bresp_o   = RESP_OKAY;
	assign rresp_o   = RESP_OKAY;

	// Port A is shared, ready strobes never overlap
	assign vram_addr_o  = wr_rdy_q ? awaddr_i[14:0] : araddr_i[14:0];
	assign vram_wdata_o = wdata_i;
	assign vram_we_o    = wr_fire && !awaddr_i[15];

	// Read stage one, register sources sampled with the address
	always_ff @(posedge clk_49m) begin
		if (rd_fire) begin
			rd_vram_q <= !araddr_i[15];
			if (is_pal(araddr_i))
				rd_byte_q <= pal_q[araddr_i[3:0]];
			else if (araddr_i == SCROLL_ADDR)
				rd_byte_q <= scroll_q;
			else
				rd_byte_q <= UNMAPPED_DATA;
		end
		if (rd_pend_q)
			rdata_o <= rd_vram_q ? vram_rdata_i : rd_byte_q;
	end

	//==================================================
	// Registers
	//==================================================

	// Palette, readable by the bus and scanout at once
	always_ff @(posedge clk_49m) begin
		if (wr_fire && is_pal(awaddr_i))
			pal_q[awaddr_i[3:0]] <= wdata_i;
	end

	assign pal_byte_o = pal_q[pal_idx_i];

	// Scroll and main latch, only data bit 0 reaches the latch
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			scroll_q <= '0;
			irq_en_q <= 1'b0;
			flip_x_o <= 1'b0;
			flip_y_o <= 1'b0;
		end else if (wr_fire) begin
			if (awaddr_i == SCROLL_ADDR)
				scroll_q <= wdata_i;
			if (is_latch(awaddr_i)) begin
				case (awaddr_i[2:0])
					LATCH_IRQ_EN: irq_en_q <= wdata_i[0];
					LATCH_FLIP_X: flip_x_o <= wdata_i[0];
					LATCH_FLIP_Y: flip_y_o <= wdata_i[0];
					default: ;
				endcase
			end
		end
	end

	assign scroll_o = scroll_q;

	// Interrupt on every other vblank, cleared by disabling it
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			irq_n_o   <= 1'b1;
			irq_tgl_q <= 1'b0;
		end else if (!irq_en_q) begin
			irq_n_o <= 1'b1;
		end else if (vblank_start_i) begin
			irq_tgl_q <= !irq_tgl_q;
			if (!irq_tgl_q)
				irq_n_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/tut_dpram.sv
//==================================================
// Dual-port byte RAM
// Port A reads and writes, port B reads only,
// both with one clock of read latency
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tut_dpram #(
	parameter int ADDR_W = 15
) (
	input  wire                clk_49m,
	input  wire                a_we_i,
	input  wire [ADDR_W-1:0]   a_addr_i,
	input  tut_pkg::byte_t     a_data_i,
	output tut_pkg::byte_t     a_q_o,
	input  wire [ADDR_W-1:0]   b_addr_i,
	output tut_pkg::byte_t     b_q_o
);
	import tut_pkg::*;

	byte_t mem [2**ADDR_W];

	// Port A returns the old byte on a write
	always_ff @(posedge clk_49m) begin
		if (a_we_i)
			mem[a_addr_i] <= a_data_i;
		a_q_o <= mem[a_addr_i];
		b_q_o <= mem[b_addr_i];
	end

endmodule

`default_nettype wire

// File: hw/tut_scanout.sv
//==================================================
// Framebuffer scanout
// Scroll and flip mapping, video RAM fetch, nibble
// select, palette lookup and RGB expansion
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tut_scanout (
	input  wire                 clk_49m,
	input  wire                 reset,
	input  wire                 ce_pix_i,
	input  tut_pkg::h_cnt_t     h_cnt_i,
	input  tut_pkg::v_cnt_t     v_cnt_i,
	input  tut_pkg::byte_t      scroll_i,
	input  wire                 flip_x_i,
	input  wire                 flip_y_i,
	output tut_pkg::vram_addr_t vram_addr_o,
	input  tut_pkg::byte_t      vram_q_i,
	output tut_pkg::pal_idx_t   pal_idx_o,
	input  tut_pkg::byte_t      pal_byte_i,
	output tut_pkg::chan_t      red_o,
	output tut_pkg::chan_t      green_o,
	output tut_pkg::chan_t      blue_o
);
	import tut_pkg::*;

	byte_t eff_x;
	byte_t eff_y;
	byte_t y_flip;
	byte_t y_ofs;
	logic  odd_q;

	//==================================================
	// Coordinate mapping
	//==================================================

	// Columns 256 and up fall in blanking, bit 8 is not needed
	always_comb begin
		eff_x  = h_cnt_i[7:0] ^ {8{flip_x_i}};
		y_flip = v_cnt_i ^ {8{flip_y_i}};
		// Right hand strip stays fixed
		y_ofs  = (eff_x < SCROLL_LIMIT) ? scroll_i : 8'd0;
		eff_y  = y_flip + y_ofs;
	end

	// Tick N, capture the fetch address, RAM answers a clock later
	always_ff @(posedge clk_49m) begin
		if (ce_pix_i) begin
			vram_addr_o <= {eff_y, eff_x[7:1]};
			odd_q       <= eff_x[0];
		end
	end

	// Two pixels per byte, odd column in the high nibble
	assign pal_idx_o = odd_q ? vram_q_i[7:4] : vram_q_i[3:0];

	//==================================================
	// Colour output
	//==================================================

	// Tick N+1, palette byte is BBGGGRRR
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else if (ce_pix_i) begin
			red_o   <= {pal_byte_i[2:0], pal_byte_i[2:1]};
			green_o <= {pal_byte_i[5:3], pal_byte_i[5:4]};
			// Two bits repeated to fill five
			blue_o  <= {pal_byte_i[7:6], pal_byte_i[7:6], pal_byte_i[7]};
		end
	end

endmodule

`default_nettype wire

// File: hw/tut_video_top.sv
//==================================================
// Tutankham video top level
// Timing, bus slave, video RAM and scanout
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tut_video_top (
	input  wire                clk_49m,
	input  wire                reset,
	// AXI4-Lite slave
	input  wire                awvalid_i,
	input  tut_pkg::bus_addr_t awaddr_i,
	output logic               awready_o,
	input  wire                wvalid_i,
	input  tut_pkg::byte_t     wdata_i,
	output logic               wready_o,
	output logic               bvalid_o,
	input  wire                bready_i,
	output logic [1:0]         bresp_o,
	input  wire                arvalid_i,
	input  tut_pkg::bus_addr_t araddr_i,
	output logic               arready_o,
	output logic               rvalid_o,
	output tut_pkg::byte_t     rdata_o,
	input  wire                rready_i,
	output logic [1:0]         rresp_o,
	// Video out
	output tut_pkg::chan_t     red_o,
	output tut_pkg::chan_t     green_o,
	output tut_pkg::chan_t     blue_o,
	output logic               hsync_n_o,
	output logic               vsync_n_o,
	output logic               hblank_o,
	output logic               vblank_o,
	output logic               ce_pix_o,
	output logic               irq_n_o
);
	import tut_pkg::*;

	h_cnt_t     h_cnt;
	v_cnt_t     v_cnt;
	logic       vblank_start;
	byte_t      scroll;
	logic       flip_x;
	logic       flip_y;
	pal_idx_t   pal_idx;
	byte_t      pal_byte;
	logic       vram_we;
	vram_addr_t vram_addr_a;
	byte_t      vram_wdata;
	byte_t      vram_q_a;
	vram_addr_t vram_addr_b;
	byte_t      vram_q_b;

	tut_video_timing u_timing (
		.clk_49m        (clk_49m),
		.reset          (reset),
		.ce_pix_o       (ce_pix_o),
		.hblank_o       (hblank_o),
		.vblank_o       (vblank_o),
		.hsync_n_o      (hsync_n_o),
		.vsync_n_o      (vsync_n_o),
		.vblank_start_o (vblank_start),
		.h_cnt_o        (h_cnt),
		.v_cnt_o        (v_cnt)
	);

	tut_bus_slave u_bus_slave (
		.clk_49m        (clk_49m),
		.reset          (reset),
		.awvalid_i      (awvalid_i),
		.awaddr_i       (awaddr_i),
		.awready_o      (awready_o),
		.wvalid_i       (wvalid_i),
		.wdata_i        (wdata_i),
		.wready_o       (wready_o),
		.bvalid_o       (bvalid_o),
		.bready_i       (bready_i),
		.bresp_o        (bresp_o),
		.arvalid_i      (arvalid_i),
		.araddr_i       (araddr_i),
		.arready_o      (arready_o),
		.rvalid_o       (rvalid_o),
		.rdata_o        (rdata_o),
		.rready_i       (rready_i),
		.rresp_o        (rresp_o),
		.vblank_start_i (vblank_start),
		.pal_idx_i      (pal_idx),
		.pal_byte_o     (pal_byte),
		.scroll_o       (scroll),
		.flip_x_o       (flip_x),
		.flip_y_o       (flip_y),
		.irq_n_o        (irq_n_o),
		.vram_we_o      (vram_we),
		.vram_addr_o    (vram_addr_a),
		.vram_wdata_o   (vram_wdata),
		.vram_rdata_i   (vram_q_a)
	);

	// 32 KB packed nibble framebuffer
	tut_dpram #(
		.ADDR_W (15)
	) u_vram (
		.clk_49m  (clk_49m),
		.a_we_i   (vram_we),
		.a_addr_i (vram_addr_a),
		.a_data_i (vram_wdata),
		.a_q_o    (vram_q_a),
		.b_addr_i (vram_addr_b),
		.b_q_o    (vram_q_b)
	);

	tut_scanout u_scanout (
		.clk_49m     (clk_49m),
		.reset       (reset),
		.ce_pix_i    (ce_pix_o),
		.h_cnt_i     (h_cnt),
		.v_cnt_i     (v_cnt),
		.scroll_i    (scroll),
		.flip_x_i    (flip_x),
		.flip_y_i    (flip_y),
		.vram_addr_o (vram_addr_b),
		.vram_q_i    (vram_q_b),
		.pal_idx_o   (pal_idx),
		.pal_byte_i  (pal_byte),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o)
	);

endmodule

`default_nettype wire

// File: verif/tb_tut_video.sv
//==================================================
// Tutankham video testbench
// Plays the stimulus file into the video top and
// checks bus reads, pixels, interrupt and timing
//==================================================

`timescale 1ns/1ps
`default_nettype none

module tb_tut_video;
	import tut_pkg::*;

	// Five full frames of system clocks
	localparam int FRAME_CYC   = H_TOTAL * V_TOTAL * PIX_DIV;
	localparam int TIMEOUT_CYC = 5 * FRAME_CYC;
	// Clocks allowed for one handshake
	localparam int HS_LIMIT    = 64;

	logic       clk_49m;
	logic       reset;
	logic       awvalid;
	bus_addr_t  awaddr;
	logic       awready;
	logic       wvalid;
	byte_t      wdata;
	logic       wready;
	logic       bvalid;
	logic       bready;
	logic [1:0] bresp;
	logic       arvalid;
	bus_addr_t  araddr;
	logic       arready;
	logic       rvalid;
	byte_t      rdata;
	logic       rready;
	logic [1:0] rresp;
	chan_t      red;
	chan_t      green;
	chan_t      blue;
	logic       hsync_n;
	logic       vsync_n;
	logic       hblank;
	logic       vblank;
	logic       ce_pix;
	logic       irq_n;

	// Raster position kept by the testbench from reset
	int tb_h = 0;
	int tb_v = 0;
	// Clocks since reset was released
	int clk_since_rst = 0;
	int cycle_cnt = 0;
	int errors = 0;
	int n_rd = 0;
	int n_pix = 0;
	int n_irq = 0;
	int seed;

	tut_video_top u_tut_video_top (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.awvalid_i (awvalid),
		.awaddr_i  (awaddr),
		.awready_o (awready),
		.wvalid_i  (wvalid),
		.wdata_i   (wdata),
		.wready_o  (wready),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.bresp_o   (bresp),
		.arvalid_i (arvalid),
		.araddr_i  (araddr),
		.arready_o (arready),
		.rvalid_o  (rvalid),
		.rdata_o   (rdata),
		.rready_i  (rready),
		.rresp_o   (rresp),
		.red_o     (red),
		.green_o   (green),
		.blue_o    (blue),
		.hsync_n_o (hsync_n),
		.vsync_n_o (vsync_n),
		.hblank_o  (hblank),
		.vblank_o  (vblank),
		.ce_pix_o  (ce_pix),
		.irq_n_o   (irq_n)
	);

	//==================================================
	// Clock, raster counters and timeout
	//==================================================

	initial clk_49m = 1'b0;
	always #50 clk_49m = !clk_49m;

	// Advance on every pixel tick, wrap per line and frame
	always @(posedge clk_49m) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!reset)
			clk_since_rst <= 0;
		else
			clk_since_rst <= clk_since_rst + 1;
		if (!reset) begin
			tb_h <= 0;
			tb_v <= 0;
		end else if (ce_pix) begin
			if (tb_h == H_TOTAL - 1) begin
				tb_h <= 0;
				tb_v <= (tb_v == V_TOTAL - 1) ? 0 : tb_v + 1;
			end else begin
				tb_h <= tb_h + 1;
			end
		end
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYC);
		$display("timeout after %0d cycles, the stimulus never finished", cycle_cnt);
		$display("Test failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
			$time, name, expected, actual);
		errors++;
	endtask

	// Sync and blank edges sit on the package constants
	always @(negedge clk_49m) begin
		logic exp_hb;
		logic exp_vb;
		logic exp_hs;
		logic exp_vs;
		logic exp_ce;
		exp_hb = (tb_h >= H_ACTIVE);
		exp_vb = (tb_v >= V_ACTIVE);
		exp_hs = !(tb_h >= H_SYNC_START && tb_h < H_SYNC_END);
		exp_vs = !(tb_v >= V_SYNC_START && tb_v < V_SYNC_END);
		// First tick on the eighth clock after release, then one per PIX_DIV
		exp_ce = reset && (clk_since_rst % PIX_DIV == PIX_DIV - 1);
		if (ce_pix !== exp_ce)
			report_mismatch("ce_pix_o", exp_ce, ce_pix);
		if (reset && ce_pix) begin
			if (hblank !== exp_hb)
				report_mismatch("hblank_o", exp_hb, hblank);
			if (vblank !== exp_vb)
				report_mismatch("vblank_o", exp_vb, vblank);
			if (hsync_n !== exp_hs)
				report_mismatch("hsync_n_o", exp_hs, hsync_n);
			if (vsync_n !== exp_vs)
				report_mismatch("vsync_n_o", exp_vs, vsync_n);
		end
	end

	//==================================================
	// Bus and video tasks
	//==================================================

	task automatic bus_write(input int addr, input int data);
		int wait_cyc;
		int delay;
		@(posedge clk_49m);
		awaddr  <= addr[15:0];
		wdata   <= data[7:0];
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		wait_cyc = 0;
		@(posedge clk_49m);
		while (!(awready && wready) && wait_cyc < HS_LIMIT) begin
			@(posedge clk_49m);
			wait_cyc++;
		end
		if (wait_cyc >= HS_LIMIT) begin
			$display("write to 0x%04h was never accepted by the slave", addr);
			errors++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		// Random back-pressure on the response
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge clk_49m);
		bready <= 1'b1;
		wait_cyc = 0;
		@(posedge clk_49m);
		while (!bvalid && wait_cyc < HS_LIMIT) begin
			@(posedge clk_49m);
			wait_cyc++;
		end
		if (wait_cyc >= HS_LIMIT) begin
			$display("write to 0x%04h never got a response", addr);
			errors++;
		end else if (bresp !== 2'b00) begin
			report_mismatch("bresp_o", 0, bresp);
		end
		bready <= 1'b0;
	endtask

	task automatic read_and_compare(input int addr, input int expected);
		int wait_cyc;
		int delay;
		byte_t got;
		@(posedge clk_49m);
		araddr  <= addr[15:0];
		arvalid <= 1'b1;
		wait_cyc = 0;
		@(posedge clk_49m);
		while (!arready && wait_cyc < HS_LIMIT) begin
			@(posedge clk_49m);
			wait_cyc++;
		end
		arvalid <= 1'b0;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge clk_49m);
		rready <= 1'b1;
		@(posedge clk_49m);
		while (!rvalid && wait_cyc < HS_LIMIT) begin
			@(posedge clk_49m);
			wait_cyc++;
		end
		got = rdata;
		rready <= 1'b0;
		n_rd++;
		if (wait_cyc >= HS_LIMIT) begin
			$display("read of 0x%04h did not complete", addr);
			errors++;
		end else begin
			if (got !== expected[7:0])
				report_mismatch($sformatf("rdata_o[0x%04h]", addr), expected, got);
			if (rresp !== 2'b00)
				report_mismatch("rresp_o", 0, rresp);
		end
	endtask

	// Colour is captured two ticks after the fetch tick
	task automatic sample_pixel(input int h, input int v, input int exp_r,
		input int exp_g, input int exp_b);
		int ticks;
		@(negedge clk_49m);
		while (!(ce_pix && tb_h == h && tb_v == v))
			@(negedge clk_49m);
		ticks = 0;
		while (ticks < 2) begin
			@(negedge clk_49m);
			if (ce_pix)
				ticks++;
		end
		n_pix++;
		if (red !== exp_r[4:0])
			report_mismatch($sformatf("red_o(%0d,%0d)", h, v), exp_r, red);
		if (green !== exp_g[4:0])
			report_mismatch($sformatf("green_o(%0d,%0d)", h, v), exp_g, green);
		if (blue !== exp_b[4:0])
			report_mismatch($sformatf("blue_o(%0d,%0d)", h, v), exp_b, blue);
	endtask

	// Count vblank starts, then look at irq_n_o a clock after the pulse
	task automatic await_vblank_irq(input int count, input int exp_irq);
		int seen;
		seen = 0;
		while (seen < count) begin
			@(negedge clk_49m);
			if (ce_pix && tb_h == H_TOTAL - 1 && tb_v == V_ACTIVE - 1)
				seen++;
		end
		repeat (2) @(negedge clk_49m);
		n_irq++;
		if (irq_n !== exp_irq[0])
			report_mismatch("irq_n_o", exp_irq, irq_n);
	endtask

	//==================================================
	// Stimulus player
	//==================================================

	initial begin
		int fd;
		int c;
		int a0;
		int a1;
		int a2;
		int a3;
		int a4;
		logic ok;
		seed    = 32'h97ff_5571;
		reset   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		repeat (3) @(posedge clk_49m);
		reset <= 1'b1;

		fd = $fopen("verif/tut_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/tut_stim.txt");
			errors++;
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				ok = 1'b1;
				if (c == "#") begin
					// Comment to end of line
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end else if (c == "W") begin
					ok = ($fscanf(fd, "%h %h", a0, a1) == 2);
					if (ok)
						bus_write(a0, a1);
				end else if (c == "R") begin
					ok = ($fscanf(fd, "%h %h", a0, a1) == 2);
					if (ok)
						read_and_compare(a0, a1);
				end else if (c == "P") begin
					ok = ($fscanf(fd, "%d %d %h %h %h", a0, a1, a2, a3, a4) == 5);
					if (ok)
						sample_pixel(a0, a1, a2, a3, a4);
				end else if (c == "I") begin
					ok = ($fscanf(fd, "%d %d", a0, a1) == 2);
					if (ok)
						await_vblank_irq(a0, a1);
				end else if (c > 32) begin
					ok = 1'b0;
				end
				if (!ok) begin
					$display("stimulus file holds a malformed or unknown line");
					errors++;
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end

		if (n_rd + n_pix + n_irq == 0) begin
			$display("no checks were run from the stimulus file");
			errors++;
		end
		$display("reads %0d, pixels %0d, irq checks %0d, errors %0d",
			n_rd, n_pix, n_irq, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tut_stim.txt
# W addr data | R addr expected | P h v red green blue | I vblanks_to_wait irq_n
# Bus values and RGB in hex, h v and vblank counts in decimal
# Palette, BBGGGRRR
W 8001 07
W 8002 38
W 8003 C0
W 8004 5A
W 8005 95
# Video RAM, row 10 and row 20 pixels
W 0564 21
W 0566 34
W 0A14 54
W 0A16 51
# Scroll bytes, row 116 is fetched left of column 192
W 3219 01
W 3A19 43
W 326E 02
W 3A6E 01
# Flip bytes at the inverted coordinates
W 34E1 51
W 2FBE 14
R 0564 21
R 3A19 43
R 8004 5A
R 8005 95
R 8100 00
R 8010 FF
R 8200 FF
R C000 FF
P 200 10 1F 00 00
P 205 10 00 00 1F
P 40 20 09 0D 0A
P 45 20 16 09 15
W 8100 10
R 8100 10
P 50 100 00 00 1F
P 220 100 00 1F 00
W 8100 00
W 8206 01
W 8207 01
P 60 150 16 09 15
P 130 160 1F 00 00
W 8206 00
W 8207 00
# Interrupt on every other vblank
W 8200 01
I 1 0
W 8200 00
I 0 1
W 8200 01
I 1 1
I 1 0
R 8003 C0

// File: all.f
hw/tut_pkg.sv
hw/tut_video_timing.sv
hw/tut_bus_slave.sv
hw/tut_dpram.sv
hw/tut_scanout.sv
hw/tut_video_top.sv
verif/tb_tut_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the video testbench with Verilator, run it and
# decide pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_tut_video -f all.f -o tb_tut_video \
	> build.log 2>&1 \
	&& ./obj_dir/tb_tut_video > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Test passed" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
